//--- source/csr_consts.svh
/* Word widths and identity constants for the CSR unit.
   Include wherever a width or an identity value is needed. */
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Data path and counter widths
`define CSR_XLEN        32
`define CSR_COUNTER_W   64
`define CSR_ECODE_W     5

// MXL=1 (32 bit) with the I and U extension bits
`define CSR_MISA_VALUE  32'h40100100

// Identity registers
`define CSR_MIMPID      32'h00000001
`define CSR_HART_ID     32'h00000000

`endif

//--- source/csr_pkg.sv
/* CSR access types: operation codes, address views and register addresses.
   Imported by the access controller, the register banks and the bus interface. */
package csr_pkg;

    // Matches the low two bits of the CSR instruction funct3
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_t;

    typedef struct packed {
        logic [1:0] rw_bits;
        logic [1:0] privilege;
        logic [7:0] sub_addr;
    } csr_addr_fields_t;

    // Raw view for decoding, field view for access checks
    typedef union packed {
        logic [11:0]      raw;
        csr_addr_fields_t fields;
    } csr_addr_u;

    localparam logic [1:0] CSR_READ_ONLY = 2'b11;

    //////////////////////////////////////////////////////////////////////
    // Machine information and trap registers
    localparam logic [11:0] CSR_MVENDORID_ADDR = 12'hF11;
    localparam logic [11:0] CSR_MARCHID_ADDR   = 12'hF12;
    localparam logic [11:0] CSR_MIMPID_ADDR    = 12'hF13;
    localparam logic [11:0] CSR_MHARTID_ADDR   = 12'hF14;
    localparam logic [11:0] CSR_MSTATUS_ADDR   = 12'h300;
    localparam logic [11:0] CSR_MISA_ADDR      = 12'h301;
    localparam logic [11:0] CSR_MIE_ADDR       = 12'h304;
    localparam logic [11:0] CSR_MTVEC_ADDR     = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH_ADDR  = 12'h340;
    localparam logic [11:0] CSR_MEPC_ADDR      = 12'h341;
    localparam logic [11:0] CSR_MCAUSE_ADDR    = 12'h342;
    localparam logic [11:0] CSR_MTVAL_ADDR     = 12'h343;
    localparam logic [11:0] CSR_MIP_ADDR       = 12'h344;

    //////////////////////////////////////////////////////////////////////
    // Counters and their user read-only aliases
    localparam logic [11:0] CSR_MCYCLE_ADDR    = 12'hB00;
    localparam logic [11:0] CSR_MINSTRET_ADDR  = 12'hB02;
    localparam logic [11:0] CSR_MCYCLEH_ADDR   = 12'hB80;
    localparam logic [11:0] CSR_MINSTRETH_ADDR = 12'hB82;
    localparam logic [11:0] CSR_CYCLE_ADDR     = 12'hC00;
    localparam logic [11:0] CSR_INSTRET_ADDR   = 12'hC02;
    localparam logic [11:0] CSR_CYCLEH_ADDR    = 12'hC80;
    localparam logic [11:0] CSR_INSTRETH_ADDR  = 12'hC82;

endpackage

//--- source/trap_pkg.sv
/* Privilege, mstatus and exception cause types for trap handling.
   Imported by the machine register bank and the top level. */
`include "csr_consts.svh"

package trap_pkg;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_t;

    // Standard RV32 mstatus layout, reserved fields read as zero
    typedef struct packed {
        logic [18:0] wpri_hi;
        logic [1:0]  mpp;
        logic [2:0]  wpri_mid;
        logic        mpie;
        logic [2:0]  wpri_lo;
        logic        mie;
        logic [2:0]  wpri_sie;
    } mstatus_t;

    localparam logic [`CSR_XLEN-1:0] CSR_MSTATUS_WMASK = 32'h00001888;

    typedef logic [`CSR_ECODE_W-1:0] ecode_t;

    //////////////////////////////////////////////////////////////////////
    // Exception codes raised by this core
    localparam ecode_t CAUSE_INST_MISALIGNED  = 5'd0;
    localparam ecode_t CAUSE_ILLEGAL_INST     = 5'd2;
    localparam ecode_t CAUSE_BREAKPOINT       = 5'd3;
    localparam ecode_t CAUSE_LOAD_MISALIGNED  = 5'd4;
    localparam ecode_t CAUSE_STORE_MISALIGNED = 5'd6;
    localparam ecode_t CAUSE_ECALL_U          = 5'd8;
    localparam ecode_t CAUSE_ECALL_M          = 5'd11;

endpackage

//--- source/csr_bus_if.sv
/* One committed CSR access from the access controller to a register bank.
   The bank returns the addressed value, or zero for an address it does not own. */
`timescale 1ns/10ps
`include "csr_consts.svh"

interface csr_bus_if
    import csr_pkg::*;
();
    logic                 commit;
    logic                 wen;
    csr_addr_u            addr;
    logic [`CSR_XLEN-1:0] wdata;
    logic [`CSR_XLEN-1:0] rdata;

    modport ctrl (
        output commit, wen, addr, wdata,
        input  rdata
    );

    modport bank (
        input  commit, wen, addr, wdata,
        output rdata
    );
endinterface

//--- source/csr_access_ctrl.sv
/* Accepts one CSR request at a time, commits it to both register banks
   and holds the old value on the response port until it is acknowledged. */
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_access_ctrl
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  csr_op_t              req_op,
    input  logic [11:0]          req_addr,
    input  logic [`CSR_XLEN-1:0] req_data,
    output logic                 resp_done,
    input  logic                 resp_ack,
    output logic [`CSR_XLEN-1:0] resp_data,
    csr_bus_if.ctrl              machine_bus,
    csr_bus_if.ctrl              counter_bus
);
    logic                 busy;
    logic                 new_request;
    logic                 commit;
    logic                 write_stage;
    logic                 writable;
    csr_op_t              op_r;
    csr_addr_u            addr_r;
    logic [`CSR_XLEN-1:0] data_r;
    logic [`CSR_XLEN-1:0] selected;
    logic [`CSR_XLEN-1:0] old_value;
    logic [`CSR_XLEN-1:0] updated;

    //////////////////////////////////////////////////////////////////////
    // Acceptance and busy tracking
    assign req_ready   = ~busy;
    assign new_request = req_valid & req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            commit      <= 1'b0;
            write_stage <= 1'b0;
        end else begin
            busy        <= (busy & ~(resp_done & resp_ack)) | new_request;
            commit      <= new_request;
            write_stage <= commit;
        end
    end

    always_ff @(posedge clk) begin
        if (new_request) begin
            op_r     <= req_op;
            addr_r   <= req_addr;
            data_r   <= req_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Old value capture and operand update
    assign selected = machine_bus.rdata | counter_bus.rdata;
    assign writable = addr_r.fields.rw_bits != CSR_READ_ONLY;

    always_ff @(posedge clk) begin
        if (commit) begin
            old_value <= selected;
            case (op_r)
                CSR_RS:  updated <= selected | data_r;
                CSR_RC:  updated <= selected & ~data_r;
                default: updated <= data_r;
            endcase
        end
    end

    // Same access goes to both banks, each decodes its own addresses
    assign machine_bus.commit = commit;
    assign machine_bus.addr   = addr_r;
    assign machine_bus.wdata  = updated;
    assign machine_bus.wen    = write_stage & writable;
    assign counter_bus.commit = commit;
    assign counter_bus.addr   = addr_r;
    assign counter_bus.wdata  = updated;
    assign counter_bus.wen    = write_stage & writable;

    //////////////////////////////////////////////////////////////////////
    // Response held until ack
    always_ff @(posedge clk) begin
        if (rst)
            resp_done <= 1'b0;
        else
            resp_done <= (resp_done & ~resp_ack) | write_stage;
    end

    assign resp_data = old_value;

    done_needs_busy: assert property (@(posedge clk) disable iff (rst)
        $rose(resp_done) |-> busy);

    // Busy holds from acceptance through the ack edge, so nothing is accepted in between
    busy_until_ack: assert property (@(posedge clk) disable iff (rst)
        new_request |=> busy until_with (resp_done && resp_ack));

endmodule

//--- source/machine_regs.sv
/* Machine trap and status registers, identity constants and privilege level.
   Takes committed CSR writes from the bus and trap events from the pipeline. */
`timescale 1ns/10ps
`include "csr_consts.svh"

module machine_regs
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    csr_bus_if.bank              bus,
    input  logic                 exception_valid,
    input  ecode_t               exception_code,
    input  logic [`CSR_XLEN-1:0] exception_pc,
    input  logic [`CSR_XLEN-1:0] exception_tval,
    input  logic                 mret,
    output priv_t                privilege,
    output logic [`CSR_XLEN-1:0] epc,
    output logic [`CSR_XLEN-1:0] trap_vector
);
    // Software, timer and external enable bits; only msip is writable in mip
    localparam logic [`CSR_XLEN-1:0] MIE_WMASK = 32'h00000888;
    localparam logic [`CSR_XLEN-1:0] MIP_WMASK = 32'h00000008;
    localparam logic [`CSR_XLEN-1:0] PC_MASK   = 32'hFFFFFFFC;

    // Legal mcause codes, one bit per exception code
    localparam logic [31:0] CAUSE_LEGAL = (32'd1 << CAUSE_INST_MISALIGNED)
                                        | (32'd1 << CAUSE_ILLEGAL_INST)
                                        | (32'd1 << CAUSE_BREAKPOINT)
                                        | (32'd1 << CAUSE_LOAD_MISALIGNED)
                                        | (32'd1 << CAUSE_STORE_MISALIGNED)
                                        | (32'd1 << CAUSE_ECALL_U)
                                        | (32'd1 << CAUSE_ECALL_M);

    mstatus_t             mstatus;
    mstatus_t             mstatus_next;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mepc;
    ecode_t               mcause;
    logic [`CSR_XLEN-1:0] mtval;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mie;
    logic [`CSR_XLEN-1:0] mip;
    logic                 cause_legal;

    function automatic logic write_hit(input logic [11:0] addr);
        return bus.wen && (bus.addr.raw == addr);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Privilege and mstatus
    always_ff @(posedge clk) begin
        if (rst)
            privilege <= PRIV_MACHINE;
        else if (mret)
            privilege <= priv_t'(mstatus.mpp);
        else if (exception_valid)
            privilege <= PRIV_MACHINE;
    end

    always_comb begin
        mstatus_next = mstatus;
        if (write_hit(CSR_MSTATUS_ADDR)) begin
            mstatus_next = mstatus_t'((mstatus & ~CSR_MSTATUS_WMASK)
                                    | (bus.wdata & CSR_MSTATUS_WMASK));
            // mpp only takes the encodings of implemented modes
            if (!(mstatus_next.mpp inside {PRIV_USER, PRIV_MACHINE}))
                mstatus_next.mpp = mstatus.mpp;
        end else if (exception_valid) begin
            mstatus_next.mpie = mstatus.mie;
            mstatus_next.mie  = 1'b0;
            mstatus_next.mpp  = privilege;
        end else if (mret) begin
            mstatus_next.mie  = mstatus.mpie;
            mstatus_next.mpie = 1'b1;
            mstatus_next.mpp  = PRIV_USER;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            mstatus <= '{mpp: PRIV_MACHINE, default: '0};
        else
            mstatus <= mstatus_next;
    end

    //////////////////////////////////////////////////////////////////////
    // Trap setup and handling registers
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec <= '0;
            mie   <= '0;
            mip   <= '0;
        end else begin
            // Direct mode only
            if (write_hit(CSR_MTVEC_ADDR))
                mtvec <= bus.wdata & PC_MASK;
            if (write_hit(CSR_MIE_ADDR))
                mie <= bus.wdata & MIE_WMASK;
            if (write_hit(CSR_MIP_ADDR))
                mip <= bus.wdata & MIP_WMASK;
        end
    end

    assign cause_legal = (bus.wdata[`CSR_XLEN-1:`CSR_ECODE_W] == '0)
                       && CAUSE_LEGAL[bus.wdata[`CSR_ECODE_W-1:0]];

    // Software writes take priority over a trap in the same cycle
    always_ff @(posedge clk) begin
        if (write_hit(CSR_MEPC_ADDR))
            mepc <= bus.wdata & PC_MASK;
        else if (exception_valid)
            mepc <= exception_pc & PC_MASK;

        if (write_hit(CSR_MCAUSE_ADDR) && cause_legal)
            mcause <= ecode_t'(bus.wdata[`CSR_ECODE_W-1:0]);
        else if (exception_valid)
            mcause <= exception_code;

        if (write_hit(CSR_MTVAL_ADDR))
            mtval <= bus.wdata;
        else if (exception_valid)
            mtval <= exception_tval;

        if (write_hit(CSR_MSCRATCH_ADDR))
            mscratch <= bus.wdata;
    end

    assign epc         = mepc;
    assign trap_vector = mtvec;

    //////////////////////////////////////////////////////////////////////
    // Read mux
    always_comb begin
        case (bus.addr.raw)
            CSR_MISA_ADDR:      bus.rdata = `CSR_MISA_VALUE;
            CSR_MVENDORID_ADDR: bus.rdata = '0;
            CSR_MARCHID_ADDR:   bus.rdata = '0;
            CSR_MIMPID_ADDR:    bus.rdata = `CSR_MIMPID;
            CSR_MHARTID_ADDR:   bus.rdata = `CSR_HART_ID;
            CSR_MSTATUS_ADDR:   bus.rdata = mstatus;
            CSR_MIE_ADDR:       bus.rdata = mie;
            CSR_MTVEC_ADDR:     bus.rdata = mtvec;
            CSR_MSCRATCH_ADDR:  bus.rdata = mscratch;
            CSR_MEPC_ADDR:      bus.rdata = mepc;
            CSR_MCAUSE_ADDR:    bus.rdata = {{(`CSR_XLEN-`CSR_ECODE_W){1'b0}}, mcause};
            CSR_MTVAL_ADDR:     bus.rdata = mtval;
            CSR_MIP_ADDR:       bus.rdata = mip;
            default:            bus.rdata = '0;
        endcase
    end

    mtvec_aligned: assert property (@(posedge clk) disable iff (rst)
        mtvec[1:0] == 2'b00);

    // mret copies mpp into privilege, so a bad mpp write would show up here
    no_supervisor: assert property (@(posedge clk) disable iff (rst)
        privilege != 2'b01 && privilege != 2'b10);

endmodule

//--- source/counter_regs.sv
/* 64-bit cycle and retired-instruction counters with writable halves.
   Serves the machine names and the user read-only aliases on the bus. */
`timescale 1ns/10ps
`include "csr_consts.svh"

module counter_regs
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    csr_bus_if.bank    bus,
    input  logic [1:0] retire_count
);
    logic [`CSR_COUNTER_W-1:0] mcycle;
    logic [`CSR_COUNTER_W-1:0] minstret;

    function automatic logic write_hit(input logic [11:0] addr);
        return bus.wen && (bus.addr.raw == addr);
    endfunction

    // A write to either half replaces that half and skips the increment
    function automatic logic [`CSR_COUNTER_W-1:0] next_count(
        input logic [`CSR_COUNTER_W-1:0] current,
        input logic                      wr_lo,
        input logic                      wr_hi,
        input logic [1:0]                inc
    );
        logic [`CSR_COUNTER_W-1:0] value;
        value = current;
        if (wr_lo)
            value[`CSR_XLEN-1:0] = bus.wdata;
        if (wr_hi)
            value[`CSR_COUNTER_W-1:`CSR_XLEN] = bus.wdata;
        if (!(wr_lo || wr_hi))
            value = value + `CSR_COUNTER_W'(inc);
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle   <= next_count(mcycle, write_hit(CSR_MCYCLE_ADDR),
                                   write_hit(CSR_MCYCLEH_ADDR), 2'd1);
            minstret <= next_count(minstret, write_hit(CSR_MINSTRET_ADDR),
                                   write_hit(CSR_MINSTRETH_ADDR), retire_count);
        end
    end

    always_comb begin
        case (bus.addr.raw)
            CSR_MCYCLE_ADDR, CSR_CYCLE_ADDR:
                bus.rdata = mcycle[`CSR_XLEN-1:0];
            CSR_MCYCLEH_ADDR, CSR_CYCLEH_ADDR:
                bus.rdata = mcycle[`CSR_COUNTER_W-1:`CSR_XLEN];
            CSR_MINSTRET_ADDR, CSR_INSTRET_ADDR:
                bus.rdata = minstret[`CSR_XLEN-1:0];
            CSR_MINSTRETH_ADDR, CSR_INSTRETH_ADDR:
                bus.rdata = minstret[`CSR_COUNTER_W-1:`CSR_XLEN];
            default:
                bus.rdata = '0;
        endcase
    end

endmodule

//--- source/csr_unit_top.sv
/* CSR unit top level for a machine and user mode RV32 core.
   Connects the access controller to the machine and counter register banks. */
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_unit_top
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    // CSR request and response
    input  logic                 req_valid,
    output logic                 req_ready,
    input  csr_op_t              req_op,
    input  logic [11:0]          req_addr,
    input  logic [`CSR_XLEN-1:0] req_data,
    output logic                 resp_done,
    input  logic                 resp_ack,
    output logic [`CSR_XLEN-1:0] resp_data,

    // Trap events
    input  logic                 exception_valid,
    input  ecode_t               exception_code,
    input  logic [`CSR_XLEN-1:0] exception_pc,
    input  logic [`CSR_XLEN-1:0] exception_tval,
    input  logic                 mret,

    input  logic [1:0]           retire_count,

    output priv_t                privilege,
    output logic [`CSR_XLEN-1:0] epc,
    output logic [`CSR_XLEN-1:0] trap_vector
);
    csr_bus_if machine_bus ();
    csr_bus_if counter_bus ();

    csr_access_ctrl csr_access_ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_op      (req_op),
        .req_addr    (req_addr),
        .req_data    (req_data),
        .resp_done   (resp_done),
        .resp_ack    (resp_ack),
        .resp_data   (resp_data),
        .machine_bus (machine_bus.ctrl),
        .counter_bus (counter_bus.ctrl)
    );

    machine_regs machine_regs_inst (
        .clk             (clk),
        .rst             (rst),
        .bus             (machine_bus.bank),
        .exception_valid (exception_valid),
        .exception_code  (exception_code),
        .exception_pc    (exception_pc),
        .exception_tval  (exception_tval),
        .mret            (mret),
        .privilege       (privilege),
        .epc             (epc),
        .trap_vector     (trap_vector)
    );

    counter_regs counter_regs_inst (
        .clk          (clk),
        .rst          (rst),
        .bus          (counter_bus.bank),
        .retire_count (retire_count)
    );

endmodule

//--- verif/csr_checker.sv
/* Watches the CSR unit responses and trap outputs and compares them with
   the expected values that the testbench presents for the running test. */
`timescale 1ns/10ps

module csr_checker
    import trap_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req_ready,
    input  logic        resp_done,
    input  logic        resp_ack,
    input  logic [31:0] resp_data,
    input  priv_t       privilege,
    input  logic [31:0] epc,
    input  logic [31:0] trap_vector,
    input  logic        trap_check,
    input  logic [95:0] test_name,
    input  logic [31:0] exp_value,
    input  logic [1:0]  exp_priv,
    input  logic [31:0] exp_vector,
    input  logic [2:0]  exp_mode,
    output int          test_count,
    output int          fail_count
);
    localparam logic [2:0] M_EXACT = 3'd0;
    localparam logic [2:0] M_RISE  = 3'd2;
    localparam logic [2:0] M_EPC   = 3'd3;

    logic [31:0] last_data;
    logic [31:0] held_data;
    logic        holding;
    logic [31:0] actual;
    logic        ok;

    initial begin
        test_count = 0;
        fail_count = 0;
        holding    = 1'b0;
        last_data  = '0;
    end

    //////////////////////////////////////////////////////////////////////
    // Per test comparison
    always @(posedge clk) begin
        if (!rst && ((resp_done && resp_ack) || trap_check)) begin
            actual = trap_check ? epc : resp_data;
            ok     = 1'b1;
            test_count++;
            if ((exp_mode == M_EXACT || exp_mode == M_EPC) && actual !== exp_value) begin
                $display("Error %0s: expected %h, actual %h", test_name, exp_value, actual);
                ok = 1'b0;
            end
            if (exp_mode == M_EPC && trap_vector !== exp_vector) begin
                $display("Error %0s: expected vector %h, actual %h",
                         test_name, exp_vector, trap_vector);
                ok = 1'b0;
            end
            if (exp_mode == M_RISE && !(actual > last_data)) begin
                $display("Error %0s: expected above %h, actual %h",
                         test_name, last_data, actual);
                ok = 1'b0;
            end
            if (privilege !== exp_priv) begin
                $display("Error %0s: expected privilege %h, actual %h",
                         test_name, exp_priv, privilege);
                ok = 1'b0;
            end
            if (ok)
                $display("%0s ok", test_name);
            else
                fail_count++;
            if (!trap_check)
                last_data = resp_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Held response stays stable and blocks new requests
    always @(posedge clk) begin
        if (!rst && resp_done) begin
            if (holding && resp_data !== held_data) begin
                $display("Response data changed while waiting for the ack in %0s", test_name);
                fail_count++;
            end
            if (req_ready) begin
                $display("Request port was ready while a response was pending in %0s",
                         test_name);
                fail_count++;
            end
        end
        holding   <= !rst && resp_done && !resp_ack;
        held_data <= resp_data;
    end

endmodule

//--- verif/csr_tb.sv
/* Testbench for the CSR unit. Walks a table of accesses and trap events,
   drives the DUT and leaves all comparing to the checker. */
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_tb
    import csr_pkg::*;
    import trap_pkg::*;
();
    localparam logic [1:0] K_ACCESS = 2'd0;
    localparam logic [1:0] K_EXC    = 2'd1;
    localparam logic [1:0] K_MRET   = 2'd2;
    // Check modes use the same encoding as the checker
    localparam logic [2:0] M_EXACT = 3'd0;
    localparam logic [2:0] M_NONE  = 3'd1;
    localparam logic [2:0] M_RISE  = 3'd2;
    localparam logic [2:0] M_EPC   = 3'd3;
    localparam logic [2:0] M_PRIV  = 3'd4;
    localparam int         WAIT_LIMIT = 200;
    localparam logic [`CSR_XLEN-1:0] TRAP_TVAL   = 32'h0000BEEF;
    localparam logic [`CSR_XLEN-1:0] VECTOR_BASE = 32'h80000100;

    typedef struct packed {
        logic [95:0] name;
        logic [1:0]  kind;
        logic [1:0]  op;
        logic [11:0] addr;
        logic [31:0] data;
        logic [1:0]  rc;
        logic [31:0] exp;
        logic [1:0]  priv;
        logic [2:0]  mode;
    } test_t;

    logic clk;
    logic rst;
    logic req_valid;
    logic req_ready;
    csr_op_t req_op;
    logic [11:0] req_addr;
    logic [`CSR_XLEN-1:0] req_data;
    logic resp_done;
    logic resp_ack;
    logic [`CSR_XLEN-1:0] resp_data;
    logic exception_valid;
    ecode_t exception_code;
    logic [`CSR_XLEN-1:0] exception_pc;
    logic [`CSR_XLEN-1:0] exception_tval;
    logic mret;
    logic [1:0] retire_count;
    priv_t privilege;
    logic [`CSR_XLEN-1:0] epc;
    logic [`CSR_XLEN-1:0] trap_vector;

    logic        trap_check;
    logic [95:0] test_name;
    logic [31:0] exp_value;
    logic [1:0]  exp_priv;
    logic [2:0]  exp_mode;
    int          test_count;
    int          fail_count;

    test_t  tests[0:47];
    int     num_tests;
    integer seed;
    logic   timed_out;

    always #4 clk = ~clk;

    csr_unit_top csr_unit_top_inst (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready), .req_op(req_op),
        .req_addr(req_addr), .req_data(req_data),
        .resp_done(resp_done), .resp_ack(resp_ack), .resp_data(resp_data),
        .exception_valid(exception_valid), .exception_code(exception_code),
        .exception_pc(exception_pc), .exception_tval(exception_tval),
        .mret(mret), .retire_count(retire_count),
        .privilege(privilege), .epc(epc), .trap_vector(trap_vector)
    );

    csr_checker checker_inst (
        .clk(clk), .rst(rst), .req_ready(req_ready),
        .resp_done(resp_done), .resp_ack(resp_ack), .resp_data(resp_data),
        .privilege(privilege), .epc(epc), .trap_vector(trap_vector),
        .trap_check(trap_check), .test_name(test_name), .exp_value(exp_value),
        .exp_priv(exp_priv), .exp_vector(VECTOR_BASE), .exp_mode(exp_mode),
        .test_count(test_count), .fail_count(fail_count)
    );

    task automatic add_test(input logic [95:0] name, input logic [1:0] kind,
                            input logic [1:0] op, input logic [11:0] addr,
                            input logic [31:0] data, input logic [1:0] rc,
                            input logic [31:0] exp, input logic [1:0] priv,
                            input logic [2:0] mode);
        tests[num_tests] = '{name, kind, op, addr, data, rc, exp, priv, mode};
        num_tests++;
    endtask

    task automatic build_table();
        num_tests = 0;
        // Reset values
        add_test("rst_mstatus", K_ACCESS, CSR_RS, CSR_MSTATUS_ADDR, 0, 0, 32'h1800, 3, M_EXACT);
        add_test("rst_misa", K_ACCESS, CSR_RS, CSR_MISA_ADDR, 0, 0, `CSR_MISA_VALUE, 3, M_EXACT);
        add_test("rst_mhartid", K_ACCESS, CSR_RS, CSR_MHARTID_ADDR, 0, 0, `CSR_HART_ID, 3, M_EXACT);
        // Read-modify-write operations on mscratch
        add_test("scr_rw", K_ACCESS, CSR_RW, CSR_MSCRATCH_ADDR, 32'hA5A5F00F, 0, 0, 3, M_NONE);
        add_test("scr_rs", K_ACCESS, CSR_RS, CSR_MSCRATCH_ADDR, 32'h00000FF0, 0,
                 32'hA5A5F00F, 3, M_EXACT);
        add_test("scr_rc", K_ACCESS, CSR_RC, CSR_MSCRATCH_ADDR, 32'hA5000000, 0,
                 32'hA5A5FFFF, 3, M_EXACT);
        add_test("scr_read", K_ACCESS, CSR_RS, CSR_MSCRATCH_ADDR, 0, 0, 32'h00A5FFFF, 3, M_EXACT);
        // Write masks
        add_test("mtvec_wr", K_ACCESS, CSR_RW, CSR_MTVEC_ADDR, 32'h80000103, 0, 0, 3, M_EXACT);
        add_test("mtvec_rd", K_ACCESS, CSR_RS, CSR_MTVEC_ADDR, 0, 0, VECTOR_BASE, 3, M_EXACT);
        add_test("mepc_wr", K_ACCESS, CSR_RW, CSR_MEPC_ADDR, 32'h00001237, 0, 0, 3, M_NONE);
        add_test("mepc_rd", K_ACCESS, CSR_RS, CSR_MEPC_ADDR, 0, 0, 32'h00001234, 3, M_EXACT);
        add_test("mstat_wr", K_ACCESS, CSR_RW, CSR_MSTATUS_ADDR, 32'hFFFFFFFF, 0,
                 32'h1800, 3, M_EXACT);
        add_test("mstat_rd", K_ACCESS, CSR_RS, CSR_MSTATUS_ADDR, 0, 0, 32'h1888, 3, M_EXACT);
        add_test("mcause_wr", K_ACCESS, CSR_RW, CSR_MCAUSE_ADDR, 32'd11, 0, 0, 3, M_NONE);
        add_test("mcause_bad", K_ACCESS, CSR_RW, CSR_MCAUSE_ADDR, 32'd10, 0, 32'd11, 3, M_EXACT);
        add_test("mcause_rd", K_ACCESS, CSR_RS, CSR_MCAUSE_ADDR, 0, 0, 32'd11, 3, M_EXACT);
        // Trap entry from machine mode with the code in the address column
        add_test("exc_m", K_EXC, 0, 12'd2, 32'h00002002, 0, 32'h00002000, 3, M_EPC);
        add_test("exc_mepc", K_ACCESS, CSR_RS, CSR_MEPC_ADDR, 0, 0, 32'h00002000, 3, M_EXACT);
        add_test("exc_mcause", K_ACCESS, CSR_RS, CSR_MCAUSE_ADDR, 0, 0, 32'd2, 3, M_EXACT);
        add_test("exc_mtval", K_ACCESS, CSR_RS, CSR_MTVAL_ADDR, 0, 0, TRAP_TVAL, 3, M_EXACT);
        add_test("exc_mstat", K_ACCESS, CSR_RS, CSR_MSTATUS_ADDR, 0, 0, 32'h1880, 3, M_EXACT);
        // mret back to user, then a trap from user mode
        add_test("mpp_user", K_ACCESS, CSR_RC, CSR_MSTATUS_ADDR, 32'h1800, 0, 32'h1880, 3, M_EXACT);
        add_test("mret_u", K_MRET, 0, 0, 0, 0, 0, 0, M_PRIV);
        add_test("mret_mstat", K_ACCESS, CSR_RS, CSR_MSTATUS_ADDR, 0, 0, 32'h0088, 0, M_EXACT);
        add_test("exc_u", K_EXC, 0, 12'd8, 32'h00003000, 0, 32'h00003000, 3, M_EPC);
        add_test("exc_u_mstat", K_ACCESS, CSR_RS, CSR_MSTATUS_ADDR, 0, 0, 32'h0080, 3, M_EXACT);
        // Counters
        add_test("instret_wr", K_ACCESS, CSR_RW, CSR_MINSTRET_ADDR, 32'd100, 0, 0, 3, M_EXACT);
        add_test("cycleh_wr", K_ACCESS, CSR_RW, CSR_MCYCLEH_ADDR, 32'd5, 0, 0, 3, M_EXACT);
        add_test("cycleh_rd", K_ACCESS, CSR_RS, CSR_MCYCLEH_ADDR, 0, 0, 32'd5, 3, M_EXACT);
        add_test("instret_rd", K_ACCESS, CSR_RS, CSR_MINSTRET_ADDR, 0, 0, 32'd100, 3, M_EXACT);
        add_test("retire_2", K_ACCESS, CSR_RS, CSR_INSTRET_ADDR, 0, 2, 32'd102, 3, M_EXACT);
        add_test("retire_1", K_ACCESS, CSR_RS, CSR_INSTRET_ADDR, 0, 1, 32'd103, 3, M_EXACT);
        add_test("cycle_a", K_ACCESS, CSR_RS, CSR_CYCLE_ADDR, 0, 0, 0, 3, M_NONE);
        add_test("cycle_b", K_ACCESS, CSR_RS, CSR_CYCLE_ADDR, 0, 0, 0, 3, M_RISE);
    endtask

    // Waits for an edge where the flag was high before the edge
    task automatic wait_flag(input bit for_done, output logic ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
            @(posedge clk);
            if (for_done ? resp_done : req_ready)
                ok = 1'b1;
        end
    endtask

    task automatic run_access(input test_t t);
        logic ok;
        int   delay;
        int   n;
        req_valid <= 1'b1;
        req_op    <= csr_op_t'(t.op);
        req_addr  <= t.addr;
        req_data  <= t.data;
        wait_flag(1'b0, ok);
        req_valid <= 1'b0;
        if (!ok) begin
            $display("Request %0s was never accepted", t.name);
            timed_out = 1'b1;
            return;
        end
        wait_flag(1'b1, ok);
        if (!ok) begin
            $display("No response for request %0s", t.name);
            timed_out = 1'b1;
            return;
        end
        // Hold off the ack to exercise back-pressure
        delay = ($random(seed) & 7) + 1;
        for (n = 0; n < delay; n++)
            @(posedge clk);
        resp_ack <= 1'b1;
        @(posedge clk);
        resp_ack <= 1'b0;
    endtask

    task automatic run_trap(input test_t t);
        if (t.kind == K_EXC) begin
            exception_valid <= 1'b1;
            exception_code  <= ecode_t'(t.addr[4:0]);
            exception_pc    <= t.data;
            exception_tval  <= TRAP_TVAL;
        end else begin
            mret <= 1'b1;
        end
        @(posedge clk);
        exception_valid <= 1'b0;
        mret            <= 1'b0;
        trap_check      <= 1'b1;
        @(posedge clk);
        trap_check      <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        req_valid = 1'b0;
        req_op = CSR_RW;
        req_addr = '0;
        req_data = '0;
        resp_ack = 1'b0;
        exception_valid = 1'b0;
        exception_code = '0;
        exception_pc = '0;
        exception_tval = '0;
        mret = 1'b0;
        retire_count = '0;
        trap_check = 1'b0;
        test_name = '0;
        exp_value = '0;
        exp_priv = '0;
        exp_mode = M_NONE;
        seed = 32'h530;
        timed_out = 1'b0;
        build_table();

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < num_tests && !timed_out; i++) begin
            @(posedge clk);
            test_name    <= tests[i].name;
            exp_value    <= tests[i].exp;
            exp_priv     <= tests[i].priv;
            exp_mode     <= tests[i].mode;
            retire_count <= tests[i].rc;
            // Retire count is a one-cycle pulse ahead of the access
            @(posedge clk);
            retire_count <= 2'd0;
            if (tests[i].kind == K_ACCESS)
                run_access(tests[i]);
            else
                run_trap(tests[i]);
        end

        repeat (2) @(posedge clk);
        $display("Tests run: %0d, failures: %0d", test_count, fail_count);
        if (timed_out || fail_count != 0) begin
            $display("Test failed");
        end else begin
            $display("Test passed");
        end
        $finish;
    end

endmodule

//--- csr_unit.f
+incdir+source
source/csr_pkg.sv
source/trap_pkg.sv
source/csr_bus_if.sv
source/csr_access_ctrl.sv
source/machine_regs.sv
source/counter_regs.sv
source/csr_unit_top.sv
verif/csr_checker.sv
verif/csr_tb.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - include_dirs:
      - source
    files:
      - source/csr_pkg.sv
      - source/trap_pkg.sv
      - source/csr_bus_if.sv
      - source/csr_access_ctrl.sv
      - source/machine_regs.sv
      - source/counter_regs.sv
      - source/csr_unit_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/csr_checker.sv
      - verif/csr_tb.sv
